// File: relayPkg.sv
package relayPkg;

	// ******************************
	// memory geometry
	// ******************************
	localparam int memDepth = 1024; // bytes.
	localparam int memAddrBits = 10; // low address bits used by memory.

	localparam logic [7:0] haltCode = 8'hAE; // HALT opcode byte.

	// ******************************
	// instruction classes from decode
	// ******************************
	typedef enum logic [3:0]
	{
		opMov8,
		opSetab,
		opAlu,
		opLoad,
		opStore,
		opMov16,
		opIncXY,
		opGoto,
		opBranchZ,
		opBranchNZ,
		opBranchC,
		opHalt,
		opNop
	} opClassE;

	typedef enum logic [3:0]
	{
		sIdle,
		sFetch,
		sIncPc,
		sExec,
		sJ1Read,
		sJ1Inc,
		sJ2Read,
		sJ2Inc,
		sJump,
		sHalt
	} seqStateE;

	// order matches the 3-bit register fields of the opcodes.
	typedef enum logic [2:0] {regA, regB, regC, regD, regM1, regM2, regX, regY} regSelE;

	typedef enum logic [2:0] {dsNone, dsReg, dsMem, dsAlu, dsImm} dataSelE;

	typedef enum logic [1:0] {asPc, asM, asXY, asJ} addrSelE;

	typedef enum logic [2:0]
	{
		aluAdd, aluInc, aluAnd, aluOr, aluXor, aluNot, aluShl, aluClr
	} aluFuncE;

endpackage

// File: relayBuses.sv
interface busIf;

	logic [15:0] addressBus;
	logic [7:0] dataBus;
	logic [7:0] memData; // memory read value.
	logic [7:0] aluResult;
	logic [7:0] immData; // SETAB value, sign extended.
	logic [15:0] pcValue;
	logic [15:0] jValue; // J1:J2.
	logic [15:0] mValue; // M1:M2.

	modport regPort (output addressBus, dataBus, mValue,
		input memData, aluResult, immData, pcValue, jValue);
	modport memPort (output memData, input addressBus, dataBus);
	modport aluPort (output aluResult);
	modport pcPort (output pcValue, jValue, immData, input addressBus, dataBus);
	modport seqPort (input pcValue);

endinterface

interface ctrlIf;

	logic [7:0] regLoad; // one-hot, indexed by regSelE.
	relayPkg::regSelE regSrc;
	relayPkg::dataSelE dataSel;
	relayPkg::addrSelE addrSel;
	relayPkg::aluFuncE aluFunc;
	logic ldInst, ldPc, ldInc, ldJ1, ldJ2;
	logic ldXY, incXY, ldCond;
	logic memRead, memWrite, halt;
	logic [7:0] instruction;
	logic zero, sign, carry; // condition register.

	modport seqPort (output regLoad, regSrc, dataSel, addrSel, aluFunc, ldInst, ldPc, ldInc,
		ldJ1, ldJ2, ldXY, incXY, ldCond, memRead, memWrite, halt,
		input instruction, zero, sign, carry);
	modport regPort (input regLoad, regSrc, dataSel, addrSel, ldXY, incXY);
	modport aluPort (input aluFunc, ldCond, output zero, sign, carry);
	modport pcPort (input ldInst, ldPc, ldInc, ldJ1, ldJ2, addrSel, output instruction);
	modport memPort (input memWrite);

endinterface

// File: sequencer.sv
module sequencer
(
	input logic clock,
	input logic rstN,
	input logic loadMem,
	busIf.seqPort bus,
	ctrlIf.seqPort ctrl,
	output relayPkg::seqStateE state
);

	relayPkg::seqStateE nextState;
	relayPkg::opClassE opClass;
	logic takeJump;

	// ******************************
	// decode
	// ******************************
	always_comb
	begin
		casez (ctrl.instruction)
			8'b00??????: opClass = relayPkg::opMov8;
			8'b01??????: opClass = relayPkg::opSetab;
			8'b1000????: opClass = relayPkg::opAlu;
			8'b100100??: opClass = relayPkg::opLoad;
			8'b100110??: opClass = relayPkg::opStore;
			8'b10100000: opClass = relayPkg::opMov16;
			8'b10100001: opClass = relayPkg::opIncXY;
			8'b11000000: opClass = relayPkg::opGoto;
			8'b11000001: opClass = relayPkg::opBranchZ;
			8'b11000010: opClass = relayPkg::opBranchNZ;
			8'b11000011: opClass = relayPkg::opBranchC;
			relayPkg::haltCode: opClass = relayPkg::opHalt;
			default: opClass = relayPkg::opNop; // unused codes.
		endcase
	end

	// flags come from the last ALU instruction.
	always_comb
	begin
		case (opClass)
			relayPkg::opGoto: takeJump = 1'b1;
			relayPkg::opBranchZ: takeJump = ctrl.zero;
			relayPkg::opBranchNZ: takeJump = !ctrl.zero;
			relayPkg::opBranchC: takeJump = ctrl.carry;
			default: takeJump = 1'b0;
		endcase
	end

	// ******************************
	// state machine
	// ******************************
	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
			state <= relayPkg::sIdle;
		else
			state <= nextState;
	end

	always_comb
	begin
		nextState = state;
		case (state)
			relayPkg::sIdle: if (bus.pcValue == '0) nextState = relayPkg::sFetch; // start at 0.
			relayPkg::sFetch: nextState = relayPkg::sIncPc;
			relayPkg::sIncPc:
			begin
				if (opClass == relayPkg::opHalt)
					nextState = relayPkg::sHalt;
				else if (opClass inside {relayPkg::opGoto, relayPkg::opBranchZ,
						relayPkg::opBranchNZ, relayPkg::opBranchC})
					nextState = relayPkg::sJ1Read;
				else
					nextState = relayPkg::sExec;
			end
			relayPkg::sExec: nextState = relayPkg::sFetch;
			relayPkg::sJ1Read: nextState = relayPkg::sJ1Inc;
			relayPkg::sJ1Inc: nextState = relayPkg::sJ2Read;
			relayPkg::sJ2Read: nextState = relayPkg::sJ2Inc;
			relayPkg::sJ2Inc: nextState = relayPkg::sJump;
			relayPkg::sJump: nextState = relayPkg::sFetch;
			relayPkg::sHalt: nextState = relayPkg::sHalt;
			default: nextState = relayPkg::sIdle;
		endcase
		if (loadMem)
			nextState = relayPkg::sIdle; // program load parks the machine.
	end

	// ******************************
	// control levels
	// ******************************
	always_comb
	begin
		ctrl.regLoad = '0;
		ctrl.regSrc = relayPkg::regA;
		ctrl.dataSel = relayPkg::dsNone;
		ctrl.addrSel = relayPkg::asPc;
		ctrl.aluFunc = relayPkg::aluAdd;
		ctrl.ldInst = 1'b0;
		ctrl.ldPc = 1'b0;
		ctrl.ldInc = 1'b0;
		ctrl.ldJ1 = 1'b0;
		ctrl.ldJ2 = 1'b0;
		ctrl.ldXY = 1'b0;
		ctrl.incXY = 1'b0;
		ctrl.ldCond = 1'b0;
		ctrl.memRead = 1'b0;
		ctrl.memWrite = 1'b0;
		ctrl.halt = (state == relayPkg::sHalt);
		case (state)
			relayPkg::sFetch, relayPkg::sJ1Read, relayPkg::sJ2Read:
			begin
				ctrl.memRead = 1'b1; // byte at PC onto the data bus.
				ctrl.dataSel = relayPkg::dsMem;
				ctrl.ldInc = 1'b1;
				ctrl.ldInst = (state == relayPkg::sFetch);
				ctrl.ldJ1 = (state == relayPkg::sJ1Read);
				ctrl.ldJ2 = (state == relayPkg::sJ2Read);
			end
			relayPkg::sIncPc, relayPkg::sJ1Inc, relayPkg::sJ2Inc: ctrl.ldPc = 1'b1;
			relayPkg::sJump:
			begin
				if (takeJump)
				begin
					ctrl.addrSel = relayPkg::asJ;
					ctrl.ldPc = 1'b1;
				end
			end
			relayPkg::sExec:
			begin
				case (opClass)
					relayPkg::opMov8:
					begin
						ctrl.regSrc = relayPkg::regSelE'(ctrl.instruction[2:0]);
						ctrl.dataSel = relayPkg::dsReg;
						ctrl.regLoad[ctrl.instruction[5:3]] = 1'b1;
					end
					relayPkg::opSetab:
					begin
						ctrl.dataSel = relayPkg::dsImm;
						ctrl.regLoad[ctrl.instruction[5] ? relayPkg::regB : relayPkg::regA] = 1'b1;
					end
					relayPkg::opAlu:
					begin
						ctrl.aluFunc = relayPkg::aluFuncE'(ctrl.instruction[2:0]);
						ctrl.dataSel = relayPkg::dsAlu;
						ctrl.ldCond = 1'b1;
						ctrl.regLoad[ctrl.instruction[3] ? relayPkg::regD : relayPkg::regA] = 1'b1;
					end
					relayPkg::opLoad:
					begin
						ctrl.addrSel = relayPkg::asM;
						ctrl.memRead = 1'b1;
						ctrl.dataSel = relayPkg::dsMem;
						ctrl.regLoad[{1'b0, ctrl.instruction[1:0]}] = 1'b1;
					end
					relayPkg::opStore:
					begin
						ctrl.addrSel = relayPkg::asM;
						ctrl.regSrc = relayPkg::regSelE'({1'b0, ctrl.instruction[1:0]});
						ctrl.dataSel = relayPkg::dsReg;
						ctrl.memWrite = 1'b1;
					end
					relayPkg::opMov16: ctrl.ldXY = 1'b1;
					relayPkg::opIncXY: ctrl.incXY = 1'b1;
					default: ; // no-op.
				endcase
			end
			default: ;
		endcase
	end

endmodule

// File: registerUnit.sv
module registerUnit
(
	input logic clock,
	input logic rstN,
	busIf.regPort bus,
	ctrlIf.regPort ctrl
);

	logic [7:0][7:0] regFile; // A..Y, indexed by regSelE.
	logic [15:0] xyValue;

	assign xyValue = {regFile[relayPkg::regX], regFile[relayPkg::regY]};
	assign bus.mValue = {regFile[relayPkg::regM1], regFile[relayPkg::regM2]};

	// ******************************
	// bus sources
	// ******************************
	always_comb
	begin
		case (ctrl.dataSel)
			relayPkg::dsReg: bus.dataBus = regFile[ctrl.regSrc];
			relayPkg::dsMem: bus.dataBus = bus.memData;
			relayPkg::dsAlu: bus.dataBus = bus.aluResult;
			relayPkg::dsImm: bus.dataBus = bus.immData;
			default: bus.dataBus = 8'h00; // bus idle.
		endcase
	end

	always_comb
	begin
		case (ctrl.addrSel)
			relayPkg::asM: bus.addressBus = bus.mValue;
			relayPkg::asXY: bus.addressBus = xyValue;
			relayPkg::asJ: bus.addressBus = bus.jValue;
			default: bus.addressBus = bus.pcValue;
		endcase
	end

	// ******************************
	// register file
	// ******************************
	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
			regFile <= '0;
		else
		begin
			for (int i = 0; i < 8; i++)
			begin
				if (ctrl.regLoad[i])
					regFile[i] <= bus.dataBus;
			end
			// 16-bit moves into X:Y.
			if (ctrl.ldXY)
				{regFile[relayPkg::regX], regFile[relayPkg::regY]} <= bus.mValue;
			else if (ctrl.incXY)
				{regFile[relayPkg::regX], regFile[relayPkg::regY]} <= xyValue + 16'd1;
		end
	end

endmodule

// File: alu.sv
module alu
(
	input logic clock,
	input logic rstN,
	busIf.aluPort bus,
	ctrlIf.aluPort ctrl,
	input logic [7:0] b,
	input logic [7:0] c
);

	logic [7:0] result;
	logic carryOut;

	always_comb
	begin
		carryOut = 1'b0; // only add and inc carry.
		case (ctrl.aluFunc)
			relayPkg::aluAdd: {carryOut, result} = {1'b0, b} + {1'b0, c};
			relayPkg::aluInc: {carryOut, result} = {1'b0, b} + 9'd1;
			relayPkg::aluAnd: result = b & c;
			relayPkg::aluOr: result = b | c;
			relayPkg::aluXor: result = b ^ c;
			relayPkg::aluNot: result = ~b;
			relayPkg::aluShl: result = {b[6:0], b[7]}; // rotate left.
			default: result = 8'h00;
		endcase
	end

	assign bus.aluResult = result;

	// condition register.
	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			ctrl.zero <= 1'b0;
			ctrl.sign <= 1'b0;
			ctrl.carry <= 1'b0;
		end
		else if (ctrl.ldCond)
		begin
			ctrl.zero <= (result == 8'h00);
			ctrl.sign <= result[7];
			ctrl.carry <= carryOut;
		end
	end

endmodule

// File: programControlUnit.sv
module programControlUnit
(
	input logic clock,
	input logic rstN,
	input logic loadMem,
	busIf.pcPort bus,
	ctrlIf.pcPort ctrl
);

	logic [15:0] pc;
	logic [15:0] incReg; // incrementer output latch.
	logic [7:0] j1, j2;
	logic [7:0] instReg;

	assign bus.pcValue = pc;
	assign bus.jValue = {j1, j2};
	assign ctrl.instruction = instReg;
	assign bus.immData = {{3{instReg[4]}}, instReg[4:0]}; // SETAB field.

	// ******************************
	// program counter
	// ******************************
	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
			pc <= 16'h0000;
		else if (loadMem)
			pc <= 16'h0000;
		else if (ctrl.ldPc)
			pc <= (ctrl.addrSel == relayPkg::asJ) ? bus.jValue : incReg; // jump or step.
	end

	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
			instReg <= 8'h00;
		else if (ctrl.ldInst)
			instReg <= bus.dataBus;
	end

	always_ff @(posedge clock)
	begin
		if (ctrl.ldInc)
			incReg <= bus.addressBus + 16'd1;
		if (ctrl.ldJ1)
			j1 <= bus.dataBus; // target high byte.
		if (ctrl.ldJ2)
			j2 <= bus.dataBus;
	end

endmodule

// File: memory.sv
module memory
(
	input logic clock,
	input logic loadMem,
	input logic [15:0] loadAddr,
	input logic [7:0] loadData,
	busIf.memPort bus,
	ctrlIf.memPort ctrl
);

	logic [7:0] mem [relayPkg::memDepth];
	logic [relayPkg::memAddrBits-1:0] readIndex;
	logic [relayPkg::memAddrBits-1:0] loadIndex;

	assign readIndex = bus.addressBus[relayPkg::memAddrBits-1:0];
	assign loadIndex = loadAddr[relayPkg::memAddrBits-1:0];

	assign bus.memData = mem[readIndex]; // combinational read.

	// program load wins over a store.
	always_ff @(posedge clock)
	begin
		if (loadMem)
			mem[loadIndex] <= loadData;
		else if (ctrl.memWrite)
			mem[readIndex] <= bus.dataBus;
	end

endmodule

// File: relayComputer.sv
module relayComputer
(
	input logic clock,
	input logic rstN,
	input logic loadMem,
	input logic [15:0] loadAddr,
	input logic [7:0] loadData,
	output logic [15:0] addressBus,
	output logic [7:0] dataBus,
	output logic memRead,
	output logic memWrite,
	output logic halt,
	output logic [7:0] instruction,
	output relayPkg::seqStateE seqState
);

	busIf bus();
	ctrlIf ctrl();

	// ******************************
	// units
	// ******************************
	sequencer seqUnit (.clock(clock), .rstN(rstN), .loadMem(loadMem),
		.bus(bus.seqPort), .ctrl(ctrl.seqPort), .state(seqState));

	registerUnit regUnit (.clock(clock), .rstN(rstN), .bus(bus.regPort), .ctrl(ctrl.regPort));

	alu aluUnit (.clock(clock), .rstN(rstN), .bus(bus.aluPort), .ctrl(ctrl.aluPort),
		.b(regUnit.regFile[relayPkg::regB]), .c(regUnit.regFile[relayPkg::regC]));

	programControlUnit pcUnit (.clock(clock), .rstN(rstN), .loadMem(loadMem),
		.bus(bus.pcPort), .ctrl(ctrl.pcPort));

	memory mem (.clock(clock), .loadMem(loadMem), .loadAddr(loadAddr), .loadData(loadData),
		.bus(bus.memPort), .ctrl(ctrl.memPort));

	// observed state.
	assign addressBus = bus.addressBus;
	assign dataBus = bus.dataBus;
	assign memRead = ctrl.memRead;
	assign memWrite = ctrl.memWrite;
	assign halt = ctrl.halt;
	assign instruction = ctrl.instruction;

endmodule

// File: clockGen.sv
module clockGen
(
	output logic clock,
	output logic rstN
);

	timeunit 1ns;
	timeprecision 100ps;

	initial
	begin
		clock = 1'b0;
		forever #2 clock = ~clock; // 4 ns period.
	end

	initial
	begin
		rstN = 1'b0;
		repeat (3) @(posedge clock);
		@(negedge clock);
		rstN = 1'b1; // released between rising edges.
	end

endmodule

// File: relayComputer_properties.sv
module relayComputer_properties
(
	input logic clock,
	input logic rstN,
	input logic loadMem,
	input logic memRead,
	input logic memWrite,
	input logic halt
);

	timeunit 1ns;
	timeprecision 100ps;

	noReadWrite: assert property (@(posedge clock) disable iff (!rstN)
		!(memRead && memWrite))
		else $error("memRead and memWrite are high in the same cycle");

	// only a program load releases the machine.
	haltHolds: assert property (@(posedge clock) disable iff (!rstN)
		(halt && !loadMem) |=> halt)
		else $error("halt dropped while loadMem was low");

	writePulse: assert property (@(posedge clock) disable iff (!rstN)
		memWrite |=> !memWrite)
		else $error("memWrite stayed high longer than one cycle");

endmodule

bind relayComputer relayComputer_properties propertyCheck (.clock(clock), .rstN(rstN),
	.loadMem(loadMem), .memRead(memRead), .memWrite(memWrite), .halt(halt));

// File: relayComputer_tb.sv
module relayComputer_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int timeoutCycles = 2000;

	logic clock;
	logic rstN;
	logic loadMem;
	logic [15:0] loadAddr;
	logic [7:0] loadData;
	logic [15:0] addressBus;
	logic [7:0] dataBus;
	logic memRead;
	logic memWrite;
	logic halt;
	logic [7:0] instruction;
	relayPkg::seqStateE seqState;

	logic [15:0] inputWords [0:127]; // length, program, store records, fetch count.
	int fetchCount = 0;

	clockGen clockUnit (.clock(clock), .rstN(rstN));

	relayComputer dut_i (.clock(clock), .rstN(rstN), .loadMem(loadMem), .loadAddr(loadAddr),
		.loadData(loadData), .addressBus(addressBus), .dataBus(dataBus), .memRead(memRead),
		.memWrite(memWrite), .halt(halt), .instruction(instruction), .seqState(seqState));

	// ******************************
	// failure reporting
	// ******************************
	task automatic failValue(input string testName, input logic [15:0] expected,
		input logic [15:0] actual);
		$display("** Error: %s expected %h actual %h", testName, expected, actual);
		$display("Verification failed");
		$fatal(1);
	endtask

	task automatic failPlain(input string what);
		$display("%s", what);
		$display("Verification failed");
		$fatal(1);
	endtask

	task automatic checkQuiet(input string phase);
		assert (!halt && !memWrite && !memRead)
		else failPlain({"halt, memWrite or memRead is high during ", phase});
	endtask

	always @(negedge clock)
	begin
		if (seqState == relayPkg::sFetch)
			fetchCount <= fetchCount + 1; // one cycle per fetched instruction.
	end

	// ******************************
	// stimulus and checks
	// ******************************
	initial
	begin
		int progLen;
		int recBase;
		int storeCount;
		int cycles;
		logic [15:0] expAddr;
		logic [7:0] expData;
		loadMem = 1'b1; // keeps the machine parked through reset.
		loadAddr = 16'h0000;
		loadData = 8'h00;
		$readmemh("program_input.txt", inputWords);
		assert (!$isunknown(inputWords[0])) else failPlain("program_input.txt could not be read");

		cycles = 0;
		do
		begin
			@(negedge clock);
			cycles++;
			checkQuiet("reset");
		end while (!rstN && cycles < timeoutCycles);
		assert (rstN) else failPlain("reset was never released");

		progLen = int'(inputWords[0]);
		for (int i = 0; i < progLen; i++)
		begin
			loadAddr = 16'(i);
			loadData = inputWords[i + 1][7:0];
			@(negedge clock);
			checkQuiet("program load");
		end
		loadMem = 1'b0; // run from address 0.

		cycles = 0;
		do
		begin
			@(negedge clock);
			cycles++;
		end while (seqState != relayPkg::sFetch && cycles < timeoutCycles);
		assert (seqState == relayPkg::sFetch) else failPlain("the sequencer never reached fetch");
		assert (addressBus == 16'h0000) else failValue("first fetch address", 16'h0000, addressBus);
		assert (memRead) else failPlain("memRead is low during the first fetch");
		assert (dataBus == inputWords[1][7:0])
		else failValue("first fetch byte", {8'h00, inputWords[1][7:0]}, {8'h00, dataBus});

		recBase = progLen + 1;
		storeCount = int'(inputWords[recBase]);
		for (int k = 0; k < storeCount; k++)
		begin
			expAddr = inputWords[recBase + 1 + 2 * k];
			expData = inputWords[recBase + 2 + 2 * k][7:0];
			cycles = 0;
			do
			begin
				@(negedge clock);
				cycles++;
				assert (!halt) else failPlain($sformatf("halt rose before store record %0d", k + 1));
			end while (!memWrite && cycles < timeoutCycles);
			assert (memWrite) else failPlain($sformatf("store record %0d never arrived", k + 1));
			assert (addressBus == expAddr)
			else failValue($sformatf("store %0d address", k + 1), expAddr, addressBus);
			assert (dataBus == expData)
			else failValue($sformatf("store %0d data", k + 1), {8'h00, expData}, {8'h00, dataBus});
			// STORE is 100110rr.
			assert (instruction[7:2] == 6'b100110)
			else failValue($sformatf("store %0d opcode", k + 1), 16'h0026,
				{10'h000, instruction[7:2]});
		end

		cycles = 0;
		do
		begin
			@(negedge clock);
			cycles++;
			assert (!memWrite)
			else failPlain($sformatf("memory write after the last record at %h", addressBus));
		end while (!halt && cycles < timeoutCycles);
		assert (halt) else failPlain("halt never rose after the last store");
		assert (instruction == 8'hAE)
		else failValue("halt opcode", 16'h00AE, {8'h00, instruction});

		for (int n = 0; n < 20; n++)
		begin
			@(negedge clock);
			assert (halt) else failPlain("halt dropped while the machine was stopped");
		end

		assert (fetchCount == int'(inputWords[recBase + 1 + 2 * storeCount]))
		else failValue("instruction count", inputWords[recBase + 1 + 2 * storeCount],
			16'(fetchCount));

		$display("Verification passed");
		$finish;
	end

endmodule

// File: program_input.txt
// hex words in order: program length, program bytes, store record count,
// store records as address then value, and the number of instructions fetched
0044
// program bytes from address 0
42 20 40 28 7D 99 65 11
7D 41 28 9A 42 28 8A 9B
43 28 8B 9B 44 28 8C 9B
45 28 8D 9B 46 28 8E 9B
47 28 89 9B 48 28 8F 9B
C1 00 2E 99 00 00 49 28
88 9B C3 00 36 99 A0 A1
26 2F 89 0B 99 C1 00 43
C0 00 36 AE
// store records
000D
0200 FD
0201 05
0202 05
0203 FD
0204 F8
0205 02
0206 FB
0207 FE
0208 00
0209 02
020A FE
020B FF
020C 00
// instructions fetched up to and including HALT
0049

// File: src.f
relayPkg.sv
relayBuses.sv
sequencer.sv
registerUnit.sv
alu.sv
programControlUnit.sv
memory.sv
relayComputer.sv
clockGen.sv
relayComputer_properties.sv
relayComputer_tb.sv

// File: run.sh
#!/usr/bin/env bash
verilator --binary --timing --assert -Wno-fatal -f src.f --top-module relayComputer_tb \
	-o simRelay \
	&& ./obj_dir/simRelay | tee /dev/stderr | grep -q "Verification passed" \
	&& exit 0 \
	|| exit 1
